//--- tb/conv_patterns.hex
// vector: k s w00 w01 w02 w10 w11 w12 w20 w21 w22, rows 0 and 1, row 2 then sums 0..3
// error case: busy_mode addr wdata check_addr check_value pslverr
// number of vectors, number of error cases
06 06
// k=3 s=1
03 01 01 02 03 ff 00 01 02 ff 00
01 02 03 04 05 06 07 08 09 0a 0b 0c 0a 0a 0a 0a 0a 0a 0a 0a 0a 0a 0a 0a
0c 0b 0a 09 08 07 06 05 04 03 02 01 0000001b 00000020 00000025 0000002a
// k=1 s=2, columns 1 and 2 carry weights that must not count
01 02 03 05 07 fe 09 09 01 04 04
01 02 03 04 05 06 07 08 09 0a 0b 0c 0a 0a 0a 0a 0a 0a 0a 0a 0a 0a 0a 0a
0c 0b 0a 09 08 07 06 05 04 03 02 01 fffffffb ffffffff 00000003 00000007
// k=2 s=2
02 02 01 ff 05 02 03 f9 fc 01 06
02 04 06 08 0a 0c 0e 10 12 14 16 18 01 02 03 04 05 06 07 08 09 0a 0b 0c
03 03 03 03 03 03 03 03 03 03 03 03 fffffffd 00000007 00000011 0000001b
// k=3 s=2
03 02 0a 14 1e ce ce ce 01 01 01
01 02 03 04 05 06 07 08 09 0a 0b 0c 01 01 01 01 01 01 01 01 01 01 01 01
64 64 64 64 64 64 64 64 64 64 64 64 00000122 0000019a 00000212 0000028a
// k=3 s=1, same rows as before with new weights
03 01 00 00 01 02 02 02 00 ff 00
01 02 03 04 05 06 07 08 09 0a 0b 0c 01 01 01 01 01 01 01 01 01 01 01 01
64 64 64 64 64 64 64 64 64 64 64 64 ffffffa5 ffffffa6 ffffffa7 ffffffa8
// k=3 s=1, weights -128 and pixels 255
03 01 80 80 80 80 80 80 80 80 80
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
ff ff ff ff ff ff ff ff ff ff ff ff fffb8480 fffb8480 fffb8480 fffb8480
// error cases
00 70 12345678 40 ffffffff 01
00 1c 7f7f7f7f 10 00808080 01
00 84 deadbeef 84 fffb8480 01
00 08 00000003 08 00000002 01
01 04 00000022 04 00000013 01
01 54 aabbccdd 54 ffffffff 01

//--- all.f
verilog/conv_pkg.sv
verilog/conv_ifs.sv
verilog/apb_cfg_decode.sv
verilog/window_shifter.sv
verilog/column_mac.sv
verilog/result_store.sv
verilog/conv_row_engine.sv
tb/tb_conv_row_engine.sv

//--- run_sim.sh
#!/bin/sh
# build and run the conv row engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_conv_row_engine \
    -f all.f -o tb_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

//--- tb/tb_conv_row_engine.sv
module tb_conv_row_engine;
    import conv_pkg::*;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;

    logic [31:0] pat [512];     // header, vectors, then error cases
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;
    logic        last_err;      // pslverr of the latest transfer
    logic [31:0] last_rdata;

    conv_row_engine uut (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: done never rose");
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////
    // APB transfers with setup then access
    ////////////////////////////////////////
    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #10 last_err = pslverr;     // settled before the completing edge
        check_value(32'(pready), 32'h1, "pready in write access");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #10 last_rdata = prdata;
        check_value(32'(pready), 32'h1, "pready in read access");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // cycles counted from the CTRL access cycle
    task automatic wait_done(input int expected_cycles, input string what);
        int n;

        n = 1;
        @(negedge clk);
        n++;
        check_value(32'(irq), 32'h0, $sformatf("%s irq cleared by start", what));
        while (!irq) begin
            @(negedge clk);
            n++;
        end
        check_value(32'(n), 32'(expected_cycles), $sformatf("%s cycles to done", what));
    endtask

    ////////////////////////////////////////
    // one pass from the pattern file
    ////////////////////////////////////////
    task automatic run_vector(input int base, input int idx);
        int          k;
        int          p;
        int          sum_base;
        logic [31:0] word;
        string       what;

        k        = int'(pat[base][3:0]);
        sum_base = base + 2 + ROWS * K_MAX + ROWS * ROW_LEN;
        what     = $sformatf("vector %0d", idx);
        write_reg(ADDR_CFG, {24'h0, pat[base+1][3:0], pat[base][3:0]});
        for (int r = 0; r < ROWS; r++) begin
            p    = base + 2 + K_MAX * r;
            word = {8'h00, pat[p+2][7:0], pat[p+1][7:0], pat[p][7:0]};
            write_reg(ADDR_WGT + 8'(4 * r), word);
        end
        for (int r = 0; r < ROWS; r++) begin
            for (int n = 0; n < ROW_LEN / 4; n++) begin
                p    = base + 2 + ROWS * K_MAX + ROW_LEN * r + 4 * n;
                word = {pat[p+3][7:0], pat[p+2][7:0], pat[p+1][7:0], pat[p][7:0]};
                write_reg(ADDR_ROW + 8'(16 * r + 4 * n), word);
            end
        end
        write_reg(ADDR_CTRL, 32'h1);
        check_value(32'(last_err), 32'h0, $sformatf("%s start write pslverr", what));
        wait_done(k + 3, what);
        for (int j = 0; j < OUT_PIX; j++) begin
            read_reg(ADDR_RES + 8'(4 * j));
            check_value(last_rdata, pat[sum_base+j], $sformatf("%s result %0d", what, j));
        end
        read_reg(ADDR_STATUS);
        check_value(last_rdata, 32'h2, $sformatf("%s status after done", what));
    endtask

    // rejected write with an optional pass running
    task automatic try_bad_write(input int base, input int idx);
        string what;

        what = $sformatf("error case %0d", idx);
        if (pat[base] != 0) begin
            write_reg(ADDR_CTRL, 32'h1);    // busy from here
        end
        write_reg(pat[base+1][7:0], pat[base+2]);
        check_value(32'(last_err), pat[base+5], $sformatf("%s pslverr", what));
        while (!irq) begin
            @(negedge clk);
        end
        read_reg(pat[base+3][7:0]);
        check_value(last_rdata, pat[base+4], $sformatf("%s stored value", what));
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        int n_vec;
        int n_err;
        int vec_words;
        int err_base;

        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        last_err    = 1'b0;
        last_rdata  = '0;
        vec_words   = 2 + ROWS * K_MAX + ROWS * ROW_LEN + OUT_PIX;
        $readmemh("tb/conv_patterns.hex", pat);
        if ($isunknown(pat[0]) || $isunknown(pat[1])) begin
            $display("could not read test vectors from tb/conv_patterns.hex");
            errors++;
            n_vec = 0;
            n_err = 0;
        end else begin
            n_vec = int'(pat[0]);
            n_err = int'(pat[1]);
        end
        cycle_limit = n_vec * 120 + 50;
        err_base    = 2 + n_vec * vec_words;

        repeat (8) @(negedge clk);
        reset = 1'b0;

        // state straight out of reset
        read_reg(ADDR_STATUS);
        check_value(last_rdata, 32'h0, "status after reset");
        check_value(32'(irq), 32'h0, "irq after reset");
        for (int j = 0; j < OUT_PIX; j++) begin
            read_reg(ADDR_RES + 8'(4 * j));
            check_value(last_rdata, 32'h0, $sformatf("result %0d after reset", j));
        end

        for (int v = 0; v < n_vec; v++) begin
            run_vector(2 + v * vec_words, v);
        end
        for (int e = 0; e < n_err; e++) begin
            try_bad_write(err_base + 6 * e, e);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog/conv_row_engine.sv
module conv_row_engine (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [conv_pkg::ADDR_W-1:0] paddr,
    input  logic [conv_pkg::DATA_W-1:0] pwdata,
    output logic [conv_pkg::DATA_W-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        irq
);
    import conv_pkg::*;

    acc_t              sums [OUT_PIX];
    logic              res_valid;
    logic [SEL_W-1:0]  res_sel;
    logic [DATA_W-1:0] res_rdata;
    logic              done;

    conv_cfg_if cfg_bus ();
    window_if   win_bus ();

    ////////////////////////////////////////
    // decode stage
    ////////////////////////////////////////
    apb_cfg_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .busy_clear (res_valid),    // busy drops as done rises
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .res_sel    (res_sel),
        .res_rdata  (res_rdata),
        .done       (done),
        .cfg        (cfg_bus)
    );

    ////////////////////////////////////////
    // execute stage
    ////////////////////////////////////////
    window_shifter u_shifter (
        .clk   (clk),
        .reset (reset),
        .cfg   (cfg_bus),
        .win   (win_bus)
    );

    column_mac u_mac (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg_bus),
        .win       (win_bus),
        .sums      (sums),
        .res_valid (res_valid)
    );

    // result stage
    result_store u_store (
        .clk       (clk),
        .reset     (reset),
        .start     (cfg_bus.start),
        .sums      (sums),
        .res_valid (res_valid),
        .res_sel   (res_sel),
        .res_rdata (res_rdata),
        .done      (done),
        .irq       (irq)
    );

endmodule

//--- verilog/result_store.sv
module result_store (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  conv_pkg::acc_t              sums [conv_pkg::OUT_PIX],
    input  logic                        res_valid,
    input  logic [conv_pkg::SEL_W-1:0]  res_sel,
    output logic [conv_pkg::DATA_W-1:0] res_rdata,
    output logic                        done,
    output logic                        irq
);
    import conv_pkg::*;

    acc_t res_q [OUT_PIX];

    ////////////////////////////////////////
    // results of the last pass
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int j = 0; j < OUT_PIX; j++) begin
                res_q[j] <= '0;
            end
        end else if (res_valid) begin
            res_q <= sums;
        end
    end

    // done until the next start
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b0;
        end else if (res_valid) begin
            done <= 1'b1;
        end
    end

    assign irq = done;      // level interrupt

    // sign extend to the bus width
    assign res_rdata = {{(DATA_W - ACC_W){res_q[res_sel][ACC_W-1]}}, res_q[res_sel]};

endmodule

//--- verilog/column_mac.sv
module column_mac (
    input  logic           clk,
    input  logic           reset,
    conv_cfg_if.mac        cfg,
    window_if.dst          win,
    output conv_pkg::acc_t sums [conv_pkg::OUT_PIX],
    output logic           res_valid
);
    import conv_pkg::*;

    acc_t col_sum [OUT_PIX];

    ////////////////////////////////////////
    // one window column, all rows
    ////////////////////////////////////////
    always_comb begin
        logic signed [16:0] prod;   // s8 x u8 fits in 17 bits

        prod = '0;
        for (int j = 0; j < OUT_PIX; j++) begin
            col_sum[j] = '0;
            for (int r = 0; r < ROWS; r++) begin
                prod       = cfg.w[r][win.col] * $signed({1'b0, win.pix[r][j]});
                col_sum[j] = col_sum[j] + ACC_W'(prod);
            end
        end
    end

    ////////////////////////////////////////
    // accumulate over k columns
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (win.valid) begin
            for (int j = 0; j < OUT_PIX; j++) begin
                if (win.col == '0) begin
                    sums[j] <= col_sum[j];              // fresh pass
                end else begin
                    sums[j] <= sums[j] + col_sum[j];
                end
            end
        end
    end

    // sums are final in the cycle after last
    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= win.valid && win.last;
        end
    end

endmodule

//--- verilog/window_shifter.sv
module window_shifter (
    input  logic      clk,
    input  logic      reset,
    conv_cfg_if.shift cfg,
    window_if.src     win
);
    import conv_pkg::*;

    row_t             shift_q [ROWS];
    logic             active;
    logic [COL_W-1:0] col_q;
    logic [3:0]       k_eff;
    logic             last_col;

    // k outside 1..K_MAX is clamped
    always_comb begin
        if (cfg.k == 4'd0) begin
            k_eff = 4'd1;
        end else if (cfg.k > 4'(K_MAX)) begin
            k_eff = 4'(K_MAX);
        end else begin
            k_eff = cfg.k;
        end
    end

    assign last_col = active && (4'(col_q) == k_eff - 4'd1);

    ////////////////////////////////////////
    // pass sequencing
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            col_q  <= '0;
        end else if (cfg.start) begin
            active <= 1'b1;         // column 0 follows the load
            col_q  <= '0;
        end else if (last_col) begin
            active <= 1'b0;
            col_q  <= '0;
        end else if (active) begin
            col_q <= col_q + 1'b1;
        end
    end

    ////////////////////////////////////////
    // row registers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int r = 0; r < ROWS; r++) begin
            if (cfg.start) begin
                shift_q[r] <= cfg.rows[r];  // parallel load
            end else if (active) begin
                // one pixel toward index 0, zero in at the top
                shift_q[r] <= {pixel_t'(0), shift_q[r][ROW_LEN-1:1]};
            end
        end
    end

    assign win.valid = active;
    assign win.last  = last_col;
    assign win.col   = col_q;

    // output j taps pixel j*s of the shifted row
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            for (int j = 0; j < OUT_PIX; j++) begin
                if (cfg.s == 4'd2) begin
                    win.pix[r][j] = shift_q[r][2*j];
                end else begin
                    win.pix[r][j] = shift_q[r][j];
                end
            end
        end
    end

endmodule

//--- verilog/apb_cfg_decode.sv
module apb_cfg_decode (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [conv_pkg::ADDR_W-1:0] paddr,
    input  logic [conv_pkg::DATA_W-1:0] pwdata,
    input  logic                        busy_clear,
    output logic [conv_pkg::DATA_W-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic [conv_pkg::SEL_W-1:0]  res_sel,
    input  logic [conv_pkg::DATA_W-1:0] res_rdata,
    input  logic                        done,
    conv_cfg_if.src                     cfg
);
    import conv_pkg::*;

    logic       access;
    logic       is_ctrl;
    logic       is_cfg;
    logic       is_status;
    logic       is_wgt;
    logic       is_row;
    logic       is_res;
    logic       mapped;
    logic       read_only;
    logic       err;
    logic       wr_ok;
    logic       go;
    logic       busy;
    logic [1:0] row_idx;
    logic [1:0] word_idx;

    assign access   = psel && penable;
    assign row_idx  = paddr[5:4];
    assign word_idx = paddr[3:2];

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////
    always_comb begin
        is_ctrl   = paddr == ADDR_CTRL;
        is_cfg    = paddr == ADDR_CFG;
        is_status = paddr == ADDR_STATUS;
        is_wgt    = paddr[7:4] == ADDR_WGT[7:4] && word_idx < 2'(ROWS)
                    && paddr[1:0] == 2'b00;
        is_row    = paddr[7:6] == ADDR_ROW[7:6] && row_idx < 2'(ROWS)
                    && word_idx < 2'(ROW_LEN / 4) && paddr[1:0] == 2'b00;
        is_res    = paddr[7:4] == ADDR_RES[7:4] && paddr[1:0] == 2'b00;
    end

    assign mapped    = is_ctrl || is_cfg || is_status || is_wgt || is_row || is_res;
    assign read_only = is_status || is_res;
    // config and rows stay frozen for the whole pass
    assign err       = !mapped || (pwrite && read_only) || (pwrite && busy && !is_status);
    assign wr_ok     = access && pwrite && !err;
    assign go        = wr_ok && is_ctrl && pwdata[0];

    assign pready  = 1'b1;          // zero wait states
    assign pslverr = access && err;
    assign res_sel = word_idx;      // result j at 0x80 + 4j

    ////////////////////////////////////////
    // control and config
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.start <= 1'b0;
            busy      <= 1'b0;
            cfg.k     <= 4'd1;
            cfg.s     <= 4'd1;
        end else begin
            cfg.start <= go;
            if (go) begin
                busy <= 1'b1;
            end else if (busy_clear) begin
                busy <= 1'b0;       // same edge that sets done
            end
            if (wr_ok && is_cfg) begin
                cfg.k <= pwdata[3:0];
                cfg.s <= pwdata[7:4];
            end
        end
    end

    // weights and row bytes
    always_ff @(posedge clk) begin
        if (wr_ok && is_wgt) begin
            for (int c = 0; c < K_MAX; c++) begin
                cfg.w[word_idx][c] <= pwdata[c*8 +: 8];
            end
        end
        if (wr_ok && is_row) begin
            for (int b = 0; b < 4; b++) begin
                cfg.rows[row_idx][word_idx*4 + b] <= pwdata[b*8 +: 8];
            end
        end
    end

    // read back, ctrl reads as zero
    always_comb begin
        prdata = '0;
        if (is_cfg) begin
            prdata[7:0] = {cfg.s, cfg.k};
        end else if (is_status) begin
            prdata[1:0] = {done, busy};
        end else if (is_wgt) begin
            for (int c = 0; c < K_MAX; c++) begin
                prdata[c*8 +: 8] = cfg.w[word_idx][c];
            end
        end else if (is_row) begin
            for (int b = 0; b < 4; b++) begin
                prdata[b*8 +: 8] = cfg.rows[row_idx][word_idx*4 + b];
            end
        end else if (is_res) begin
            prdata = res_rdata;
        end
    end

endmodule

//--- verilog/conv_ifs.sv
// configuration from the register block to the execute stage
interface conv_cfg_if;
    import conv_pkg::*;

    logic [3:0] k;                  // kernel width
    logic [3:0] s;                  // stride
    row_t       rows [ROWS];
    weight_t    w [ROWS][K_MAX];    // w[row][column]
    logic       start;              // one cycle per pass

    modport src (output k, s, rows, w, start);
    modport shift (input k, s, rows, start);
    modport mac (input w);

endinterface

// one window column per cycle, shifter to mac
interface window_if;
    import conv_pkg::*;

    logic             valid;
    logic             last;         // with the final column
    logic [COL_W-1:0] col;
    pixel_t           pix [ROWS][OUT_PIX];

    modport src (output valid, last, col, pix);
    modport dst (input valid, last, col, pix);

endinterface

//--- verilog/conv_pkg.sv
package conv_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int ROW_LEN = 12;    // pixels per row register
    localparam int ROWS    = 3;     // kernel height, fixed
    localparam int OUT_PIX = 4;     // output positions per pass
    localparam int K_MAX   = 3;     // widest kernel
    localparam int ACC_W   = 20;
    localparam int COL_W   = $clog2(K_MAX);
    localparam int SEL_W   = $clog2(OUT_PIX);
    localparam int ADDR_W  = 8;
    localparam int DATA_W  = 32;

    ////////////////////////////////////////
    // register map, byte offsets
    ////////////////////////////////////////
    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 8'h00;  // bit 0 starts a pass
    localparam logic [ADDR_W-1:0] ADDR_CFG    = 8'h04;  // k in 3:0, s in 7:4
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 8'h08;  // busy, done
    localparam logic [ADDR_W-1:0] ADDR_WGT    = 8'h10;  // one word per kernel row
    localparam logic [ADDR_W-1:0] ADDR_ROW    = 8'h40;  // 16 bytes per row
    localparam logic [ADDR_W-1:0] ADDR_RES    = 8'h80;  // one word per result

    ////////////////////////////////////////
    // data types
    ////////////////////////////////////////
    typedef logic [7:0] pixel_t;
    typedef logic signed [7:0] weight_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // pixel 0 sits in the low byte
    typedef pixel_t [ROW_LEN-1:0] row_t;

endpackage
